/* design/vmul_arith_pkg.sv */
package vmul_arith_pkg;

	// data path widths
	localparam int vec_w  = 64;
	localparam int addr_w = 32;

	// lane operand is a 17-bit signed value carried in 18 bits
	localparam int opnd_w = 18;
	localparam int prod_w = 34;
	localparam int wide_w = 67;

	localparam int num_lanes = 4;

	// element width, the 64-bit code is not supported
	typedef enum logic [1:0] {
		SEW_8    = 2'b00,
		SEW_16   = 2'b01,
		SEW_32   = 2'b10,
		SEW_RSVD = 2'b11
	} sew_e;

	// low bits follow the vector multiply funct6 encoding
	typedef enum logic [1:0] {
		MUL_LO = 2'b01,
		MULH   = 2'b11,
		MULHU  = 2'b00,
		MULHSU = 2'b10
	} mul_op_e;

endpackage

/* design/vmul_flow_pkg.sv */
package vmul_flow_pkg;

	// results the sink can hold
	localparam int result_credits = 4;

	// accept to result, in cycles
	localparam int pipe_depth = 4;

	// wide enough to hold result_credits itself
	localparam int credit_cnt_w = 3;

endpackage

/* design/mul_lane_if.sv */
interface mul_lane_if
	import vmul_arith_pkg::*;
();

	// operand halves, a0/b0 low and a1/b1 high
	logic [opnd_w-1:0] a0;
	logic [opnd_w-1:0] a1;
	logic [opnd_w-1:0] b0;
	logic [opnd_w-1:0] b1;

	// short products and the 32-bit product
	logic [prod_w-1:0] p0;
	logic [prod_w-1:0] p1;
	logic [wide_w-1:0] prod;

	modport sel (output a0, a1, b0, b1);

	modport lane (input a0, a1, b0, b1, output p0, p1, prod);

	modport fmt (input p0, p1, prod);

endinterface

/* design/credit_gate.sv */
module credit_gate
	import vmul_arith_pkg::*;
	import vmul_flow_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              valid,
	input  logic              credit,
	input  logic [addr_w-1:0] addr,
	output logic              ready,
	output logic              accept,
	output logic              out_valid,
	output logic [addr_w-1:0] out_addr
);

	logic [credit_cnt_w-1:0] credit_cnt;
	logic [pipe_depth-1:0]   vld_pipe;
	logic [addr_w-1:0]       addr_pipe [pipe_depth];

	assign ready  = (credit_cnt != '0);
	assign accept = valid && ready;

	// one credit per accept, one back per consumed result
	always_ff @(posedge clk) begin
		if (rst) begin
			credit_cnt <= credit_cnt_w'(result_credits);
		end else begin
			case ({accept, credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// valid and address ride alongside the data path
	always_ff @(posedge clk) begin
		if (rst) begin
			vld_pipe <= '0;
			for (int i = 0; i < pipe_depth; i++) begin
				addr_pipe[i] <= '0;
			end
		end else begin
			vld_pipe <= {vld_pipe[pipe_depth-2:0], accept};
			if (accept) begin
				addr_pipe[0] <= addr;
			end else begin
				addr_pipe[0] <= '0;
			end
			for (int i = 1; i < pipe_depth; i++) begin
				addr_pipe[i] <= addr_pipe[i-1];
			end
		end
	end

	assign out_valid = vld_pipe[pipe_depth-1];
	assign out_addr  = addr_pipe[pipe_depth-1];

endmodule

/* design/operand_select.sv */
module operand_select
	import vmul_arith_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic [vec_w-1:0] vec0,
	input  logic [vec_w-1:0] vec1,
	input  logic             accept,
	input  sew_e             sew,
	input  mul_op_e          op,
	mul_lane_if.sel          lane0,
	mul_lane_if.sel          lane1,
	mul_lane_if.sel          lane2,
	mul_lane_if.sel          lane3
);

	logic a_signed;
	logic b_signed;
	logic [opnd_w-1:0] a_lo [num_lanes];
	logic [opnd_w-1:0] a_hi [num_lanes];
	logic [opnd_w-1:0] b_lo [num_lanes];
	logic [opnd_w-1:0] b_hi [num_lanes];
	logic [4*opnd_w-1:0] opnd_q [num_lanes];

	function automatic logic [opnd_w-1:0] ext8(input logic [7:0] v, input logic s);
		return {{(opnd_w-8){s & v[7]}}, v};
	endfunction

	function automatic logic [opnd_w-1:0] ext16(input logic [15:0] v, input logic s);
		return {{(opnd_w-16){s & v[15]}}, v};
	endfunction

	// low half of the product is the same for either extension
	assign a_signed = (op != MULHU);
	assign b_signed = (op == MULH) || (op == MUL_LO);

	always_comb begin
		for (int i = 0; i < num_lanes; i++) begin
			a_lo[i] = '0;
			a_hi[i] = '0;
			b_lo[i] = '0;
			b_hi[i] = '0;
		end
		case (sew)
			SEW_8: begin
				// two byte elements per lane
				for (int i = 0; i < num_lanes; i++) begin
					a_lo[i] = ext8(vec0[16*i +: 8], a_signed);
					a_hi[i] = ext8(vec0[16*i+8 +: 8], a_signed);
					b_lo[i] = ext8(vec1[16*i +: 8], b_signed);
					b_hi[i] = ext8(vec1[16*i+8 +: 8], b_signed);
				end
			end
			SEW_16: begin
				for (int i = 0; i < num_lanes; i++) begin
					a_lo[i] = ext16(vec0[16*i +: 16], a_signed);
					b_lo[i] = ext16(vec1[16*i +: 16], b_signed);
				end
			end
			SEW_32: begin
				// halves on lanes 0 and 3, low halves always unsigned
				a_lo[0] = ext16(vec0[15:0], 1'b0);
				a_hi[0] = ext16(vec0[31:16], a_signed);
				b_lo[0] = ext16(vec1[15:0], 1'b0);
				b_hi[0] = ext16(vec1[31:16], b_signed);
				a_lo[3] = ext16(vec0[47:32], 1'b0);
				a_hi[3] = ext16(vec0[63:48], a_signed);
				b_lo[3] = ext16(vec1[47:32], 1'b0);
				b_hi[3] = ext16(vec1[63:48], b_signed);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < num_lanes; i++) begin
			if (rst || !accept) begin
				opnd_q[i] <= '0;
			end else begin
				opnd_q[i] <= {a_lo[i], a_hi[i], b_lo[i], b_hi[i]};
			end
		end
	end

	assign {lane0.a0, lane0.a1, lane0.b0, lane0.b1} = opnd_q[0];
	assign {lane1.a0, lane1.a1, lane1.b0, lane1.b1} = opnd_q[1];
	assign {lane2.a0, lane2.a1, lane2.b0, lane2.b1} = opnd_q[2];
	assign {lane3.a0, lane3.a1, lane3.b0, lane3.b1} = opnd_q[3];

endmodule

/* design/mult32.sv */
module mult32
	import vmul_arith_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	mul_lane_if.lane lane
);

	logic [prod_w-1:0] a0_x;
	logic [prod_w-1:0] a1_x;
	logic [prod_w-1:0] b0_x;
	logic [prod_w-1:0] b1_x;
	logic [prod_w-1:0] pp_00;
	logic [prod_w-1:0] pp_11;
	logic [prod_w-1:0] pp_01;
	logic [prod_w-1:0] pp_10;
	logic [wide_w-1:0] sum;

	function automatic logic [prod_w-1:0] ext_opnd(input logic [opnd_w-1:0] v);
		return {{(prod_w-opnd_w){v[opnd_w-1]}}, v};
	endfunction

	function automatic logic [wide_w-1:0] ext_prod(input logic [prod_w-1:0] v);
		return {{(wide_w-prod_w){v[prod_w-1]}}, v};
	endfunction

	// true products fit in prod_w, so the truncated product is exact
	assign a0_x = ext_opnd(lane.a0);
	assign a1_x = ext_opnd(lane.a1);
	assign b0_x = ext_opnd(lane.b0);
	assign b1_x = ext_opnd(lane.b1);

	// hi*hi at 32, cross terms at 16
	assign sum = (ext_prod(pp_11) << 32)
		+ ((ext_prod(pp_01) + ext_prod(pp_10)) << 16)
		+ ext_prod(pp_00);

	// partial products
	always_ff @(posedge clk) begin
		if (rst) begin
			pp_00 <= '0;
			pp_11 <= '0;
			pp_01 <= '0;
			pp_10 <= '0;
		end else begin
			pp_00 <= a0_x * b0_x;
			pp_11 <= a1_x * b1_x;
			pp_01 <= a0_x * b1_x;
			pp_10 <= a1_x * b0_x;
		end
	end

	// short products and the summed wide product
	always_ff @(posedge clk) begin
		if (rst) begin
			lane.p0   <= '0;
			lane.p1   <= '0;
			lane.prod <= '0;
		end else begin
			lane.p0   <= pp_00;
			lane.p1   <= pp_11;
			lane.prod <= sum;
		end
	end

endmodule

/* design/result_format.sv */
module result_format
	import vmul_arith_pkg::*;
	import vmul_flow_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             accept,
	input  sew_e             sew,
	input  mul_op_e          op,
	mul_lane_if.fmt          lane0,
	mul_lane_if.fmt          lane1,
	mul_lane_if.fmt          lane2,
	mul_lane_if.fmt          lane3,
	output logic [vec_w-1:0] vec
);

	// one stage each for operands and the two multiplier stages
	sew_e    sew_q [pipe_depth-1];
	mul_op_e op_q  [pipe_depth-1];
	logic    [pipe_depth-2:0] vld_q;
	logic    hi;
	logic    [vec_w-1:0] word;

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q <= '0;
			for (int i = 0; i < pipe_depth-1; i++) begin
				sew_q[i] <= SEW_8;
				op_q[i]  <= MUL_LO;
			end
		end else begin
			vld_q    <= {vld_q[pipe_depth-3:0], accept};
			sew_q[0] <= sew;
			op_q[0]  <= op;
			for (int i = 1; i < pipe_depth-1; i++) begin
				sew_q[i] <= sew_q[i-1];
				op_q[i]  <= op_q[i-1];
			end
		end
	end

	// high ops take the element-width bits above the low half
	always_comb begin
		hi = (op_q[pipe_depth-2] != MUL_LO);
		case (sew_q[pipe_depth-2])
			SEW_8: begin
				if (hi) begin
					word = {lane3.p1[15:8], lane3.p0[15:8], lane2.p1[15:8], lane2.p0[15:8],
						lane1.p1[15:8], lane1.p0[15:8], lane0.p1[15:8], lane0.p0[15:8]};
				end else begin
					word = {lane3.p1[7:0], lane3.p0[7:0], lane2.p1[7:0], lane2.p0[7:0],
						lane1.p1[7:0], lane1.p0[7:0], lane0.p1[7:0], lane0.p0[7:0]};
				end
			end
			SEW_16: begin
				if (hi) begin
					word = {lane3.p0[31:16], lane2.p0[31:16], lane1.p0[31:16], lane0.p0[31:16]};
				end else begin
					word = {lane3.p0[15:0], lane2.p0[15:0], lane1.p0[15:0], lane0.p0[15:0]};
				end
			end
			SEW_32: begin
				// lanes 1 and 2 sit idle here
				if (hi) begin
					word = {lane3.prod[63:32], lane0.prod[63:32]};
				end else begin
					word = {lane3.prod[31:0], lane0.prod[31:0]};
				end
			end
			default: word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vec <= '0;
		end else if (vld_q[pipe_depth-2]) begin
			vec <= word;
		end else begin
			vec <= '0;
		end
	end

endmodule

/* design/vmul_top.sv */
module vmul_top
	import vmul_arith_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	input  logic              out_credit,
	input  logic [vec_w-1:0]  in_vec0,
	input  logic [vec_w-1:0]  in_vec1,
	input  sew_e              in_sew,
	input  mul_op_e           in_op,
	input  logic [addr_w-1:0] in_addr,
	output logic              in_ready,
	output logic              out_valid,
	output logic [vec_w-1:0]  out_vec,
	output logic [addr_w-1:0] out_addr
);

	logic accept;

	mul_lane_if lane0 ();
	mul_lane_if lane1 ();
	mul_lane_if lane2 ();
	mul_lane_if lane3 ();

	credit_gate u_credit (
		.clk       (clk),
		.rst       (rst),
		.valid     (in_valid),
		.credit    (out_credit),
		.addr      (in_addr),
		.ready     (in_ready),
		.accept    (accept),
		.out_valid (out_valid),
		.out_addr  (out_addr)
	);

	operand_select u_opsel (
		.clk    (clk),
		.rst    (rst),
		.vec0   (in_vec0),
		.vec1   (in_vec1),
		.accept (accept),
		.sew    (in_sew),
		.op     (in_op),
		.lane0  (lane0),
		.lane1  (lane1),
		.lane2  (lane2),
		.lane3  (lane3)
	);

	mult32 m0 (.clk(clk), .rst(rst), .lane(lane0));
	mult32 m1 (.clk(clk), .rst(rst), .lane(lane1));
	mult32 m2 (.clk(clk), .rst(rst), .lane(lane2));
	mult32 m3 (.clk(clk), .rst(rst), .lane(lane3));

	result_format u_fmt (
		.clk    (clk),
		.rst    (rst),
		.accept (accept),
		.sew    (in_sew),
		.op     (in_op),
		.lane0  (lane0),
		.lane1  (lane1),
		.lane2  (lane2),
		.lane3  (lane3),
		.vec    (out_vec)
	);

endmodule

/* bench/vmul_assertions.sv */
module vmul_assertions
	import vmul_flow_pkg::*;
(
	input logic                    clk,
	input logic                    rst,
	input logic                    ready,
	input logic                    accept,
	input logic                    credit,
	input logic                    out_valid,
	input logic [credit_cnt_w-1:0] credit_cnt
);

	int fails = 0;

	// a returned credit always leaves at least one free
	ready_after_return: assert property (@(posedge clk) disable iff (rst)
		credit |=> ready)
		else begin
			fails++;
			$error("ready still low after a credit came back");
		end

	credit_bound: assert property (@(posedge clk) disable iff (rst)
		credit_cnt <= credit_cnt_w'(result_credits))
		else begin
			fails++;
			$error("credit count above the number of result credits");
		end

	// result valid lines up with the accept pipe_depth edges back
	valid_latency: assert property (@(posedge clk) disable iff (rst)
		out_valid == $past(accept, pipe_depth))
		else begin
			fails++;
			$error("out_valid does not follow accept by the pipeline depth");
		end

	// while blocked the count moves only by a returned credit
	blocked_holds_count: assert property (@(posedge clk) disable iff (rst)
		!ready |=> credit_cnt == credit_cnt_w'($past(credit)))
		else begin
			fails++;
			$error("credit count changed by an accept while ready was low");
		end

endmodule

/* bench/vmul_checker.sv */
module vmul_checker
	import vmul_arith_pkg::*;
	import vmul_flow_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	input  logic              in_ready,
	input  logic              out_credit,
	input  logic [vec_w-1:0]  in_vec0,
	input  logic [vec_w-1:0]  in_vec1,
	input  sew_e              in_sew,
	input  mul_op_e           in_op,
	input  logic [addr_w-1:0] in_addr,
	input  logic              out_valid,
	input  logic [vec_w-1:0]  out_vec,
	input  logic [addr_w-1:0] out_addr,
	output int                value_errs,
	output int                order_errs,
	output int                flow_errs,
	output int                pending
);

	logic [vec_w-1:0]  exp_vec [$];
	logic [addr_w-1:0] exp_addr [$];
	int                acc_cyc [$];
	int                cyc = 0;
	int                credits;

	// per-element product, high or low half by opcode
	function automatic logic [vec_w-1:0] model_mul(input logic [vec_w-1:0] x,
		input logic [vec_w-1:0] y, input sew_e s, input mul_op_e o);
		logic [vec_w-1:0] r;
		logic [63:0] mask;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] p;
		int w;
		r = '0;
		case (s)
			SEW_8:   w = 8;
			SEW_16:  w = 16;
			SEW_32:  w = 32;
			default: return '0;
		endcase
		mask = (64'd1 << w) - 64'd1;
		for (int e = 0; e < vec_w / w; e++) begin
			a = (x >> (e * w)) & mask;
			b = (y >> (e * w)) & mask;
			if ((o == MULH || o == MULHSU) && a[w-1]) begin
				a = a | ~mask;
			end
			if (o == MULH && b[w-1]) begin
				b = b | ~mask;
			end
			p = a * b;
			p = (o == MUL_LO) ? (p & mask) : ((p >> w) & mask);
			r = r | (p << (e * w));
		end
		return r;
	endfunction

	always @(negedge clk) begin
		cyc++;
		if (rst) begin
			value_errs = 0;
			order_errs = 0;
			flow_errs  = 0;
			credits    = result_credits;
		end else begin
			if (out_valid && exp_vec.size() == 0) begin
				order_errs++;
				$display("result for address %h arrived with no request outstanding", out_addr);
			end else if (out_valid) begin
				if (out_vec !== exp_vec[0] || out_addr !== exp_addr[0]) begin
					value_errs++;
					$display("error %0t: got %h at %h, expected %h at %h", $time,
						out_vec, out_addr, exp_vec[0], exp_addr[0]);
				end
				if (cyc - acc_cyc[0] != pipe_depth) begin
					order_errs++;
					$display("result for address %h came %0d cycles after its accept",
						out_addr, cyc - acc_cyc[0]);
				end
				void'(exp_vec.pop_front());
				void'(exp_addr.pop_front());
				void'(acc_cyc.pop_front());
			end else if (out_vec !== '0 || out_addr !== '0) begin
				value_errs++;
				$display("error %0t: outputs %h %h not zero while idle", $time, out_vec, out_addr);
			end
			// ready only while a credit is left
			if (in_ready !== (credits > 0)) begin
				flow_errs++;
				$display("error %0t: in_ready %b with %0d credits left", $time,
					in_ready, credits);
			end
			// compared first, so a new request never meets its own slot
			if (in_valid && in_ready) begin
				exp_vec.push_back(model_mul(in_vec0, in_vec1, in_sew, in_op));
				exp_addr.push_back(in_addr);
				acc_cyc.push_back(cyc);
				credits--;
			end
			if (out_credit) begin
				credits++;
			end
		end
		pending = exp_vec.size();
	end

endmodule

/* bench/vmul_tb.sv */
module vmul_tb
	import vmul_arith_pkg::*;
	import vmul_flow_pkg::*;
();

	localparam int          num_reqs     = 2000;
	localparam int          clk_period   = 100;
	localparam int          drive_dly    = 5;
	localparam int          reset_cycles = 4;
	localparam logic [31:0] seed         = 32'h9de9_a163;
	localparam int          timeout      = (num_reqs * 10 + 100) * clk_period;

	logic              clk = 1'b0;
	logic              rst;
	logic              in_valid;
	logic              out_credit;
	logic [vec_w-1:0]  in_vec0;
	logic [vec_w-1:0]  in_vec1;
	sew_e              in_sew;
	mul_op_e           in_op;
	logic [addr_w-1:0] in_addr;
	logic              in_ready;
	logic              out_valid;
	logic [vec_w-1:0]  out_vec;
	logic [addr_w-1:0] out_addr;
	int                value_errs;
	int                order_errs;
	int                flow_errs;
	int                pending;
	int                cyc;
	int                accepted;
	int                assert_fails;
	int                credit_due [$];
	bit                sending;

	vmul_top DUT (.*);

	vmul_checker u_check (.*);

	bind credit_gate vmul_assertions chk_flow (.clk(clk), .rst(rst), .ready(ready),
		.accept(accept), .credit(credit), .out_valid(out_valid), .credit_cnt(credit_cnt));

	always #(clk_period / 2) clk = ~clk;

	// all ones, minimum signed per element, zero, or random
	function automatic logic [vec_w-1:0] pick_operand(input sew_e s);
		case ($urandom_range(9, 0))
			0: return '1;
			1: return (s == SEW_32) ? {2{32'h8000_0000}} :
				(s == SEW_16) ? {4{16'h8000}} : {8{8'h80}};
			2: return '0;
			default: return {$urandom, $urandom};
		endcase
	endfunction

	// one credit back per cycle, oldest due first found
	task automatic return_credit();
		int idx;
		idx = -1;
		foreach (credit_due[i]) begin
			if (idx < 0 && credit_due[i] <= cyc) begin
				idx = i;
			end
		end
		out_credit = (idx >= 0);
		if (idx >= 0) begin
			credit_due.delete(idx);
		end
	endtask

	task automatic run_cycle();
		@(posedge clk);
		#drive_dly;
		cyc++;
		in_valid = sending && ($urandom_range(99, 0) < 70);
		in_sew   = sew_e'($urandom_range(3, 0));
		in_op    = mul_op_e'($urandom_range(3, 0));
		in_vec0  = pick_operand(in_sew);
		in_vec1  = pick_operand(in_sew);
		in_addr  = $urandom;
		return_credit();
		@(negedge clk);
		if (in_valid && in_ready) begin
			accepted++;
		end
		if (out_valid) begin
			credit_due.push_back(cyc + int'($urandom_range(6, 0)));
		end
	endtask

	initial begin
		#(timeout);
		$display("timeout: the run did not finish in %0d clock periods", timeout / clk_period);
		$display("Something failed");
		$finish;
	end

	initial begin
		void'($urandom(seed));
		rst        = 1'b1;
		in_valid   = 1'b0;
		out_credit = 1'b0;
		in_vec0    = '0;
		in_vec1    = '0;
		in_sew     = SEW_8;
		in_op      = MUL_LO;
		in_addr    = '0;
		cyc        = 0;
		accepted   = 0;
		sending    = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#drive_dly;
		rst = 1'b0;
		while (accepted < num_reqs) begin
			run_cycle();
		end
		sending = 1'b0;
		repeat (pipe_depth + 2) run_cycle();
		while (credit_due.size() != 0) begin
			run_cycle();
		end
		run_cycle();
		assert_fails = DUT.u_credit.chk_flow.fails;
		if (pending != 0) begin
			$display("%0d accepted requests never produced a result", pending);
		end
		$display("summary: %0d value, %0d order, %0d flow, %0d missing, %0d assertion errors",
			value_errs, order_errs, flow_errs, pending, assert_fails);
		if (value_errs + order_errs + flow_errs + pending + assert_fails == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* vmul.f */
design/vmul_arith_pkg.sv
design/vmul_flow_pkg.sv
design/mul_lane_if.sv
design/credit_gate.sv
design/operand_select.sv
design/mult32.sv
design/result_format.sv
design/vmul_top.sv
bench/vmul_assertions.sv
bench/vmul_checker.sv
bench/vmul_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= vmul_tb
FILELIST   ?= vmul.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
FAIL_MSG   ?= Something failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
